//--- Bender.yml
package:
  name: rvCore

sources:
  - rvCorePkg.sv
  - fetchStage.sv
  - decodeStage.sv
  - registerFile.sv
  - executeStage.sv
  - memWriteback.sv
  - rvCore.sv
  - target: test
    files:
      - tb_rvCore.sv

//--- all.f
rvCorePkg.sv
fetchStage.sv
decodeStage.sv
registerFile.sv
executeStage.sv
memWriteback.sv
rvCore.sv
tb_rvCore.sv

//--- decodeStage.sv
/* Decodes ALU ops, LUI, LW and SW; any other word leaves as a bubble
   A load followed by a dependent instruction costs one stall cycle */
`timescale 1ns/1ps
`default_nettype none

module decodeStage import rvCorePkg::*; #(
  parameter int numRegs = 32
) (
  input  logic                    Clock,
  input  logic                    reset,
  input  logic                    instrValid,
  input  logic [dataWidth-1:0]    instruction,
  output logic                    stall,
  output logic [regAddrWidth-1:0] rs1Addr,
  output logic [regAddrWidth-1:0] rs2Addr,
  input  logic [dataWidth-1:0]    rs1Data,
  input  logic [dataWidth-1:0]    rs2Data,
  output logic                    exValid,
  output aluOpT                   exAluOp,
  output logic                    exUseImm,
  output logic                    exIsLui,
  output logic                    exIsLoad,
  output logic                    exIsStore,
  output logic                    exRegWrEn,
  output logic [regAddrWidth-1:0] exRd,
  output logic [regAddrWidth-1:0] exRs1,
  output logic [regAddrWidth-1:0] exRs2,
  output logic [dataWidth-1:0]    exImm,
  output logic [dataWidth-1:0]    exRs1Data,
  output logic [dataWidth-1:0]    exRs2Data
);

  opcodeT                  opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [regAddrWidth-1:0] rd;
  logic                    rs1Used;
  logic                    rs2Used;
  logic                    legal;     // Inside the kept subset
  aluOpT                   aluOp;
  immFormatT               immFormat;
  logic [dataWidth-1:0]    imm;

  //////////////////////////////
  // Field extraction
  //////////////////////////////
  assign opcode  = opcodeT'(instruction[6:0]);
  assign funct3  = instruction[14:12];
  assign funct7  = instruction[31:25];
  assign rd      = instruction[11:7];
  assign rs1Addr = instruction[19:15];
  assign rs2Addr = instruction[24:20];

  assign rs1Used = opcode inside {opOp, opOpImm, opLoad, opStore}; // LUI reads nothing
  assign rs2Used = opcode inside {opOp, opStore};

  // ALU op and legality
  always_comb begin
    aluOp = aluAdd; // Address add for LW and SW
    case (opcode)
      opLui:           legal = 1'b1;
      opLoad, opStore: legal = (funct3 == 3'b010); // Word access only
      opOp, opOpImm: begin
        case (funct3)
          3'b000:  aluOp = (opcode == opOp && funct7[5]) ? aluSub : aluAdd;
          3'b001:  aluOp = aluSll;
          3'b010:  aluOp = aluSlt;
          3'b011:  aluOp = aluSltu;
          3'b100:  aluOp = aluXor;
          3'b101:  aluOp = funct7[5] ? aluSra : aluSrl;
          3'b110:  aluOp = aluOr;
          default: aluOp = aluAnd;
        endcase
        // funct7 is immediate bits for OP_IMM except shifts
        legal = (opcode == opOpImm && funct3[1:0] != 2'b01) || (funct7 == 7'b0) ||
                (funct7 == 7'b0100000 &&
                 (funct3 == 3'b101 || (opcode == opOp && funct3 == 3'b000)));
      end
      default: legal = 1'b0;
    endcase
  end

  //////////////////////////////
  // Immediate generator
  //////////////////////////////
  assign immFormat = (opcode == opLui)   ? immU :
                     (opcode == opStore) ? immS :
                                           immI;

  always_comb begin
    case (immFormat)
      immU:    imm = {instruction[31:12], 12'b0};
      immS:    imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
      default: imm = {{20{instruction[31]}}, instruction[31:20]};
    endcase
  end

  // Load-use check against the load now in execute
  assign stall = instrValid && exValid && exIsLoad && (exRd != '0) &&
                 ((rs1Used && rs1Addr == exRd) || (rs2Used && rs2Addr == exRd));

  //////////////////////////////
  // Q102 register
  //////////////////////////////
  always_ff @(posedge Clock) begin
    if (reset) begin
      exValid <= 1'b0;
    end else begin
      exValid <= instrValid && legal && !stall; // Bubble on stall or bad word
    end
  end

  always_ff @(posedge Clock) begin
    exAluOp   <= aluOp;
    exUseImm  <= (opcode != opOp);
    exIsLui   <= (opcode == opLui);
    exIsLoad  <= (opcode == opLoad);
    exIsStore <= (opcode == opStore);
    exRegWrEn <= (opcode != opStore);
    exRd      <= rd;
    exRs1     <= rs1Used ? rs1Addr : '0; // Unused source never matches a forward
    exRs2     <= rs2Used ? rs2Addr : '0;
    exImm     <= imm;
    exRs1Data <= rs1Data;
    exRs2Data <= rs2Data;
  end

  // Hardware drops these silently
  subsetOnly: assert property (@(posedge Clock) disable iff (reset)
    instrValid |-> legal);

  regIndexInRange: assert property (@(posedge Clock) disable iff (reset)
    instrValid && legal |-> (!rs1Used || rs1Addr < numRegs) &&
                            (!rs2Used || rs2Addr < numRegs) &&
                            (opcode == opStore || rd < numRegs));

endmodule : decodeStage

`default_nettype wire

//--- executeStage.sv
/* Forwarding priority: memory stage, then write-back, then the decode read
   A load in the memory stage is never a source here, decode stalls first */
`timescale 1ns/1ps
`default_nettype none

module executeStage import rvCorePkg::*; (
  input  logic                    Clock,
  input  logic                    reset,
  input  logic                    exValid,
  input  aluOpT                   exAluOp,
  input  logic                    exUseImm,
  input  logic                    exIsLui,
  input  logic                    exIsLoad,
  input  logic                    exIsStore,
  input  logic                    exRegWrEn,
  input  logic [regAddrWidth-1:0] exRd,
  input  logic [regAddrWidth-1:0] exRs1,
  input  logic [regAddrWidth-1:0] exRs2,
  input  logic [dataWidth-1:0]    exImm,
  input  logic [dataWidth-1:0]    exRs1Data,
  input  logic [dataWidth-1:0]    exRs2Data,
  input  logic                    wbEn,
  input  logic [regAddrWidth-1:0] wbAddr,
  input  logic [dataWidth-1:0]    wbData,
  output logic                    memValid,
  output logic [dataWidth-1:0]    memAluOut,
  output logic [dataWidth-1:0]    memStoreData,
  output logic                    memIsLoad,
  output logic                    memIsStore,
  output logic                    memRegWrEn,
  output logic [regAddrWidth-1:0] memRd
);

  logic [dataWidth-1:0] op1;    // Forwarded rs1
  logic [dataWidth-1:0] op2;    // Forwarded rs2, also store data
  logic [dataWidth-1:0] aluIn2;
  logic [dataWidth-1:0] aluOut;
  logic [4:0]           shamt;

  //////////////////////////////
  // Operand forwarding
  //////////////////////////////
  function automatic logic [dataWidth-1:0] forward(
    input logic [regAddrWidth-1:0] rs,
    input logic [dataWidth-1:0]    regData
  );
    if (rs != '0 && memValid && memRegWrEn && memRd == rs) begin
      return memAluOut; // Youngest producer
    end else if (wbEn && wbAddr == rs) begin
      return wbData;    // wbEn already low for x0
    end
    return regData;
  endfunction

  always_comb begin
    op1 = forward(exRs1, exRs1Data);
    op2 = forward(exRs2, exRs2Data);
  end

  //////////////////////////////
  // ALU
  //////////////////////////////
  assign aluIn2 = exUseImm ? exImm : op2;
  assign shamt  = aluIn2[4:0];

  always_comb begin
    case (exAluOp)
      aluAdd:  aluOut = op1 + aluIn2; // Also LW and SW address
      aluSub:  aluOut = op1 - aluIn2;
      aluSll:  aluOut = op1 << shamt;
      aluSlt:  aluOut = {{(dataWidth-1){1'b0}}, ($signed(op1) < $signed(aluIn2))};
      aluSltu: aluOut = {{(dataWidth-1){1'b0}}, (op1 < aluIn2)};
      aluXor:  aluOut = op1 ^ aluIn2;
      aluSrl:  aluOut = op1 >> shamt;
      aluSra:  aluOut = $signed(op1) >>> shamt;
      aluOr:   aluOut = op1 | aluIn2;
      default: aluOut = op1 & aluIn2;
    endcase
    if (exIsLui) begin
      aluOut = exImm; // Upper immediate passes straight through
    end
  end

  // Q103 register
  always_ff @(posedge Clock) begin
    if (reset) begin
      memValid <= 1'b0;
    end else begin
      memValid <= exValid;
    end
  end

  always_ff @(posedge Clock) begin
    memAluOut    <= aluOut;
    memStoreData <= op2;
    memIsLoad    <= exIsLoad;
    memIsStore   <= exIsStore;
    memRegWrEn   <= exRegWrEn;
    memRd        <= exRd;
  end

  // Load data is not back yet, so memAluOut would be its address
  noLoadForward: assert property (@(posedge Clock) disable iff (reset)
    exValid && memValid && memIsLoad && memRd != '0 |->
      memRd != exRs1 && memRd != exRs2);

endmodule : executeStage

`default_nettype wire

//--- fetchStage.sv
/* Instruction memory answers one cycle after the address, no flow control
   During a stall the PC holds and the previous word is presented again */
`timescale 1ns/1ps
`default_nettype none

module fetchStage import rvCorePkg::*; #(
  parameter logic [dataWidth-1:0] resetPc = '0
) (
  input  logic                 Clock,
  input  logic                 reset,
  input  logic                 stall,
  output logic [dataWidth-1:0] imemAddress,
  input  logic [dataWidth-1:0] imemData,
  output logic                 instrValid,
  output logic [dataWidth-1:0] instruction
);

  logic [dataWidth-1:0] pc;        // Q100 address
  logic [dataWidth-1:0] heldInstr; // Word handed to decode last cycle
  logic                 stallQ;    // Stall seen last cycle

  assign imemAddress = pc;

  always_ff @(posedge Clock) begin
    if (reset) begin
      pc         <= resetPc;
      instrValid <= 1'b0;
      stallQ     <= 1'b0;
    end else begin
      if (!stall) begin
        pc <= pc + dataWidth'(4);
      end
      instrValid <= 1'b1; // First word lands next cycle
      stallQ     <= stall;
    end
  end

  always_ff @(posedge Clock) begin
    heldInstr <= instruction;
  end

  // Memory data arrives for the address after the held one, so replay once
  assign instruction = !instrValid ? nopInstruction :
                       stallQ      ? heldInstr      :
                                     imemData;

  // One bubble frees the load-dependent instruction
  stallOneCycle: assert property (@(posedge Clock) disable iff (reset)
    stall |=> !stall);

endmodule : fetchStage

`default_nettype wire

//--- memWriteback.sv
/* Data memory returns read data one cycle after dmemRdEn, no flow control
   Word accesses only; the address is not checked for alignment */
`timescale 1ns/1ps
`default_nettype none

module memWriteback import rvCorePkg::*; (
  input  logic                    Clock,
  input  logic                    reset,
  input  logic                    memValid,
  input  logic [dataWidth-1:0]    memAluOut,
  input  logic [dataWidth-1:0]    memStoreData,
  input  logic                    memIsLoad,
  input  logic                    memIsStore,
  input  logic                    memRegWrEn,
  input  logic [regAddrWidth-1:0] memRd,
  output logic [dataWidth-1:0]    dmemAddress,
  output logic [dataWidth-1:0]    dmemWrData,
  output logic                    dmemWrEn,
  output logic                    dmemRdEn,
  input  logic [dataWidth-1:0]    dmemRdData,
  output logic                    wbEn,
  output logic [regAddrWidth-1:0] wbAddr,
  output logic [dataWidth-1:0]    wbData
);

  logic                 wbIsLoad;
  logic [dataWidth-1:0] wbAluOut; // Q104 ALU result

  // Memory port straight from Q103
  assign dmemAddress = memAluOut;
  assign dmemWrData  = memStoreData;
  assign dmemWrEn    = memValid && memIsStore;
  assign dmemRdEn    = memValid && memIsLoad;

  always_ff @(posedge Clock) begin
    if (reset) begin
      wbEn <= 1'b0;
    end else begin
      wbEn <= memValid && memRegWrEn && (memRd != '0); // x0 never written
    end
  end

  always_ff @(posedge Clock) begin
    wbAddr   <= memRd;
    wbIsLoad <= memIsLoad;
    wbAluOut <= memAluOut;
  end

  assign wbData = wbIsLoad ? dmemRdData : wbAluOut; // Load data lands this cycle

endmodule : memWriteback

`default_nettype wire

//--- registerFile.sv
/* x0 is hardwired to zero and has no storage; writes to it are dropped
   Same-cycle read of the register being written returns the new value */
`timescale 1ns/1ps
`default_nettype none

module registerFile import rvCorePkg::*; #(
  parameter int numRegs = 32
) (
  input  logic                    Clock,
  input  logic                    reset,
  input  logic [regAddrWidth-1:0] rs1Addr,
  input  logic [regAddrWidth-1:0] rs2Addr,
  output logic [dataWidth-1:0]    rs1Data,
  output logic [dataWidth-1:0]    rs2Data,
  input  logic                    wbEn,
  input  logic [regAddrWidth-1:0] wbAddr,
  input  logic [dataWidth-1:0]    wbData
);

  logic [dataWidth-1:0] regs [1:numRegs-1];

  always_ff @(posedge Clock) begin
    if (reset) begin
      for (int i = 1; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEn && wbAddr != '0 && wbAddr < numRegs) begin
      regs[wbAddr] <= wbData;
    end
  end

  // Read ports, write-through bypass ahead of the array
  assign rs1Data = (rs1Addr == '0)             ? '0     :
                   (wbEn && wbAddr == rs1Addr) ? wbData :
                                                 regs[rs1Addr];

  assign rs2Data = (rs2Addr == '0)             ? '0     :
                   (wbEn && wbAddr == rs2Addr) ? wbData :
                                                 regs[rs2Addr];

endmodule : registerFile

`default_nettype wire

//--- rvCore.sv
/* Five-stage RV32I subset core, no branches or jumps, word loads and stores
   Both memories are external with a one-cycle synchronous read */
`timescale 1ns/1ps
`default_nettype none

module rvCore import rvCorePkg::*; #(
  parameter logic [dataWidth-1:0] resetPc = '0,
  parameter int                   numRegs = 32 // 16 for an RV32E-style core
) (
  input  logic                 Clock,
  input  logic                 reset,
  output logic [dataWidth-1:0] imemAddress,
  input  logic [dataWidth-1:0] imemData,
  output logic [dataWidth-1:0] dmemAddress,
  output logic [dataWidth-1:0] dmemWrData,
  output logic                 dmemWrEn,
  output logic                 dmemRdEn,
  input  logic [dataWidth-1:0] dmemRdData
);

  // Fetch to decode
  logic                    stall;
  logic                    instrValid;
  logic [dataWidth-1:0]    instruction;

  // Register file ports
  logic [regAddrWidth-1:0] rs1Addr;
  logic [regAddrWidth-1:0] rs2Addr;
  logic [dataWidth-1:0]    rs1Data;
  logic [dataWidth-1:0]    rs2Data;

  // Q102
  logic                    exValid;
  aluOpT                   exAluOp;
  logic                    exUseImm;
  logic                    exIsLui;
  logic                    exIsLoad;
  logic                    exIsStore;
  logic                    exRegWrEn;
  logic [regAddrWidth-1:0] exRd;
  logic [regAddrWidth-1:0] exRs1;
  logic [regAddrWidth-1:0] exRs2;
  logic [dataWidth-1:0]    exImm;
  logic [dataWidth-1:0]    exRs1Data;
  logic [dataWidth-1:0]    exRs2Data;

  // Q103
  logic                    memValid;
  logic [dataWidth-1:0]    memAluOut;
  logic [dataWidth-1:0]    memStoreData;
  logic                    memIsLoad;
  logic                    memIsStore;
  logic                    memRegWrEn;
  logic [regAddrWidth-1:0] memRd;

  // Q104 write-back, also a forwarding source
  logic                    wbEn;
  logic [regAddrWidth-1:0] wbAddr;
  logic [dataWidth-1:0]    wbData;

  //////////////////////////////
  // Stages
  //////////////////////////////
  fetchStage #(.resetPc(resetPc)) i_fetchStage (
    .Clock, .reset, .stall,
    .imemAddress, .imemData,
    .instrValid, .instruction
  );

  decodeStage #(.numRegs(numRegs)) i_decodeStage (
    .Clock, .reset, .instrValid, .instruction, .stall,
    .rs1Addr, .rs2Addr, .rs1Data, .rs2Data,
    .exValid, .exAluOp, .exUseImm, .exIsLui, .exIsLoad, .exIsStore, .exRegWrEn,
    .exRd, .exRs1, .exRs2, .exImm, .exRs1Data, .exRs2Data
  );

  registerFile #(.numRegs(numRegs)) i_registerFile (
    .Clock, .reset,
    .rs1Addr, .rs2Addr, .rs1Data, .rs2Data,
    .wbEn, .wbAddr, .wbData
  );

  executeStage i_executeStage (
    .Clock, .reset,
    .exValid, .exAluOp, .exUseImm, .exIsLui, .exIsLoad, .exIsStore, .exRegWrEn,
    .exRd, .exRs1, .exRs2, .exImm, .exRs1Data, .exRs2Data,
    .wbEn, .wbAddr, .wbData,
    .memValid, .memAluOut, .memStoreData, .memIsLoad, .memIsStore, .memRegWrEn, .memRd
  );

  memWriteback i_memWriteback (
    .Clock, .reset,
    .memValid, .memAluOut, .memStoreData, .memIsLoad, .memIsStore, .memRegWrEn, .memRd,
    .dmemAddress, .dmemWrData, .dmemWrEn, .dmemRdEn, .dmemRdData,
    .wbEn, .wbAddr, .wbData
  );

endmodule : rvCore

`default_nettype wire

//--- rvCorePkg.sv
/* Shared types for the RV32I subset core: ALU ops, LUI, LW and SW only
   Opcode values follow the base ISA encoding */
`default_nettype none

package rvCorePkg;

  // Datapath widths
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;

  // Major opcodes still decoded, bits [6:0]
  typedef enum logic [6:0] {
    opLoad  = 7'b0000011,
    opOpImm = 7'b0010011,
    opStore = 7'b0100011,
    opOp    = 7'b0110011,
    opLui   = 7'b0110111
  } opcodeT;

  // ALU functions, decode to execute
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd
  } aluOpT;

  // Immediate layouts left after dropping branches and jumps
  typedef enum logic [1:0] {
    immI,
    immS,
    immU
  } immFormatT;

  localparam logic [dataWidth-1:0] nopInstruction = 32'h0000_0013; // ADDI x0,x0,0

endpackage : rvCorePkg

`default_nettype wire

//--- tb_rvCore.sv
/* Random program with a directed forwarding and load-use prefix, 64 random instructions and
   closing stores of x1..x7. Registers x0..x7 only, loads and stores use base x0 */
`timescale 1ns/1ps
`default_nettype none

module tb_rvCore import rvCorePkg::*; ();

  localparam logic [dataWidth-1:0] resetPc = 32'h0000_0080;
  localparam int numRegs     = 16;
  localparam int randomCount = 64;

  logic                 Clock = 1'b0;
  logic                 reset;
  logic [dataWidth-1:0] imemAddress;
  logic [dataWidth-1:0] imemData;
  logic [dataWidth-1:0] dmemAddress;
  logic [dataWidth-1:0] dmemWrData;
  logic                 dmemWrEn;
  logic                 dmemRdEn;
  logic [dataWidth-1:0] dmemRdData;
  logic [dataWidth-1:0] imemOffset;

  logic [31:0] prog  [0:255]; // Instruction memory image
  logic [31:0] dmem  [0:63];
  logic [31:0] mreg  [0:31];  // ISA model state
  logic [31:0] mdmem [0:63];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [31:0] repeatQ [$];   // Fetch addresses expected twice
  logic [31:0] prevAddr;
  logic [31:0] dirRepeatAddr;
  logic [4:0]  lastLoadRd;
  logic        started = 1'b0;
  logic        programReady = 1'b0;
  int seed;
  int progLen;
  int storesSeen;
  int zeroStoreIdx;
  int dirRepeatSeen;
  int checks;
  int totalErr;
  int errReset;
  int errFetch;
  int errStall;
  int errStore;
  int errFinal;
  int errZero;

  always #4 Clock = ~Clock; // 8 ns period

  rvCore #(.resetPc(resetPc), .numRegs(numRegs)) i_rvCore (
    .Clock, .reset, .imemAddress, .imemData,
    .dmemAddress, .dmemWrData, .dmemWrEn, .dmemRdEn, .dmemRdData
  );

  //////////////////////////////
  // Memories with a one-cycle read
  //////////////////////////////
  assign imemOffset = imemAddress - resetPc;

  always @(posedge Clock) begin
    imemData <= (imemOffset < 32'd1024) ? prog[imemOffset[9:2]] : nopInstruction;
    if (dmemWrEn) dmem[dmemAddress[7:2]] <= dmemWrData;
    if (dmemRdEn) dmemRdData <= dmem[dmemAddress[7:2]];
  end

  function automatic logic [31:0] fillWord(input int i);
    return (i * 32'h9E37_79B9) ^ 32'h5A5A_C3C3; // Every index bit matters
  endfunction

  // Instruction encoders
  function automatic logic [31:0] buildR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opOp};
  endfunction

  function automatic logic [31:0] buildImm(input immFormatT fmt, input opcodeT op,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm);
    case (fmt)
      immS:    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
      immU:    return {imm[31:12], rd, op};
      default: return {imm[11:0], rs1, f3, rd, op};
    endcase
  endfunction

  //////////////////////////////
  // ISA model run in program order
  //////////////////////////////
  task automatic modelStep(input logic [31:0] w, input int idx);
    logic [6:0]  op;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [31:0] a, b, res, iImm, sImm, addr;
    op   = w[6:0];
    rd   = w[11:7];
    f3   = w[14:12];
    rs1  = w[19:15];
    rs2  = w[24:20];
    iImm = {{20{w[31]}}, w[31:20]};
    sImm = {{20{w[31]}}, w[31:25], w[11:7]};
    a    = mreg[rs1];
    b    = (op == opOp) ? mreg[rs2] : iImm;
    res  = '0;
    // Consumer right behind a load costs one replayed fetch
    if (lastLoadRd != 5'd0 && ((op != opLui && rs1 == lastLoadRd) ||
        ((op == opOp || op == opStore) && rs2 == lastLoadRd)))
      repeatQ.push_back(resetPc + 32'(4 * idx) + 32'd4);
    lastLoadRd = (op == opLoad) ? rd : 5'd0;
    case (op)
      opLui:  res = {w[31:12], 12'b0};
      opLoad: begin
        addr = a + iImm;
        res  = mdmem[addr[7:2]];
      end
      opStore: begin
        addr = a + sImm;
        expAddr.push_back(addr);
        expData.push_back(mreg[rs2]);
        mdmem[addr[7:2]] = mreg[rs2];
      end
      default: begin
        case (f3)
          3'd0: res = (op == opOp && w[30]) ? a - b : a + b;
          3'd1: res = a << b[4:0];
          3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd3: res = (a < b) ? 32'd1 : 32'd0;
          3'd4: res = a ^ b;
          3'd5: begin
            if (w[30]) res = $signed(a) >>> b[4:0]; // Sign bit fills from the left
            else res = a >> b[4:0];
          end
          3'd6: res = a | b;
          default: res = a & b;
        endcase
      end
    endcase
    if (op != opStore && rd != 5'd0) mreg[rd] = res; // x0 stays zero
  endtask

  task automatic addInstr(input logic [31:0] w);
    prog[progLen] = w;
    modelStep(w, progLen);
    progLen++;
  endtask

  task automatic buildProgram();
    logic [31:0] rnd, rnd2, imm;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    // Dependent chains at distance 1, 2 and 3
    addInstr(buildImm(immI, opOpImm, 3'b000, 5'd1, 5'd0, 5'd0, 32'h123));
    addInstr(buildImm(immI, opOpImm, 3'b001, 5'd2, 5'd1, 5'd0, 32'd4));
    addInstr(buildR(7'b0100000, 5'd1, 5'd2, 3'b000, 5'd3));     // SUB x3,x2,x1
    addInstr(buildR(7'b0, 5'd1, 5'd3, 3'b110, 5'd4));           // x1 via write-through
    addInstr(buildImm(immU, opLui, 3'b000, 5'd5, 5'd0, 5'd0, 32'hABCD_E000));
    addInstr(buildR(7'b0, 5'd4, 5'd5, 3'b100, 5'd6));
    addInstr(buildR(7'b0100000, 5'd2, 5'd5, 3'b101, 5'd7));     // SRA x7,x5,x2
    addInstr(buildImm(immS, opStore, 3'b010, 5'd0, 5'd0, 5'd7, 32'd40)); // Store data forward
    addInstr(buildImm(immS, opStore, 3'b010, 5'd0, 5'd0, 5'd6, 32'd36));
    addInstr(buildImm(immS, opStore, 3'b010, 5'd0, 5'd0, 5'd3, 32'd16));
    // Load-use pair
    addInstr(buildImm(immI, opLoad, 3'b010, 5'd5, 5'd0, 5'd0, 32'd16));
    dirRepeatAddr = resetPc + 32'(4 * progLen) + 32'd4;
    addInstr(buildR(7'b0, 5'd1, 5'd5, 3'b000, 5'd6));
    addInstr(buildImm(immS, opStore, 3'b010, 5'd0, 5'd0, 5'd6, 32'd24)); // Sum with loaded word
    // x0 write then x0 store
    addInstr(buildImm(immI, opOpImm, 3'b000, 5'd0, 5'd0, 5'd0, 32'h55));
    zeroStoreIdx = expAddr.size();
    addInstr(buildImm(immS, opStore, 3'b010, 5'd0, 5'd0, 5'd0, 32'd20));
    for (int n = 0; n < randomCount; n++) begin
      rnd  = $random(seed);
      rnd2 = $random(seed);
      rd   = {2'b00, rnd[2:0]};
      rs1  = {2'b00, rnd[5:3]};
      rs2  = {2'b00, rnd[8:6]};
      f3   = rnd[11:9];
      case (rnd[15:13])
        3'd0, 3'd1, 3'd2: begin
          f7 = (rnd[16] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
          addInstr(buildR(f7, rs2, rs1, f3, rd));
        end
        3'd3, 3'd4: begin
          imm = {{20{rnd2[11]}}, rnd2[11:0]};
          if (f3 == 3'b001) imm = {27'b0, rnd2[4:0]};  // Shift amounts only
          if (f3 == 3'b101) imm = {20'b0, rnd[16] ? 7'b0100000 : 7'b0, rnd2[4:0]};
          addInstr(buildImm(immI, opOpImm, f3, rd, rs1, 5'd0, imm));
        end
        3'd5: addInstr(buildImm(immU, opLui, 3'b000, rd, 5'd0, 5'd0, {rnd2[19:0], 12'b0}));
        3'd6: addInstr(buildImm(immI, opLoad, 3'b010, rd, 5'd0, 5'd0,
                                {24'b0, rnd2[5:0], 2'b00}));
        default: addInstr(buildImm(immS, opStore, 3'b010, 5'd0, 5'd0, rs2,
                                   {24'b0, rnd2[5:0], 2'b00}));
      endcase
    end
    for (int k = 1; k < 8; k++) begin
      addInstr(buildImm(immS, opStore, 3'b010, 5'd0, 5'd0, 5'(k), 32'(196 + 4 * k)));
    end
    programReady = 1'b1;
  endtask

  //////////////////////////////
  // Output monitor sampled at negedge
  //////////////////////////////
  task automatic checkEnablesLow(input string phase);
    if (dmemWrEn !== 1'b0) begin
      $display("FAIL dmemWrEn %s: expected 0, got %h", phase, dmemWrEn);
      errReset++;
    end
    if (dmemRdEn !== 1'b0) begin
      $display("FAIL dmemRdEn %s: expected 0, got %h", phase, dmemRdEn);
      errReset++;
    end
  endtask

  task automatic checkStore();
    logic lastSeven;
    lastSeven = (storesSeen >= expAddr.size() - 7);
    checks++;
    if (storesSeen >= expAddr.size()) begin
      $display("Store beyond the expected count at address %h", dmemAddress);
      errStore++;
    end else begin
      if (dmemAddress !== expAddr[storesSeen]) begin
        $display("FAIL dmemAddress: expected %h, got %h", expAddr[storesSeen], dmemAddress);
        if (lastSeven) errFinal++;
        else errStore++;
      end
      if (dmemWrData !== expData[storesSeen]) begin
        $display("FAIL dmemWrData: expected %h, got %h", expData[storesSeen], dmemWrData);
        if (storesSeen == zeroStoreIdx) errZero++;
        else if (lastSeven) errFinal++;
        else errStore++;
      end
    end
    storesSeen++;
  endtask

  always @(negedge Clock) begin
    if (reset) begin
      checks++;
      checkEnablesLow("during reset");
    end else if (!started) begin
      started  = 1'b1;
      checks++;
      if (imemAddress !== resetPc) begin
        $display("FAIL imemAddress: expected %h, got %h", resetPc, imemAddress);
        errReset++;
      end
      checkEnablesLow("after reset");
      prevAddr = imemAddress;
      $display("Test reset finished, %0d errors", errReset);
    end else begin
      checks++;
      if (imemAddress == prevAddr) begin
        if (repeatQ.size() == 0 || repeatQ[0] != imemAddress) begin
          $display("FAIL imemAddress: expected %h, got repeated %h",
                   prevAddr + 32'd4, imemAddress);
          errStall++;
        end else begin
          repeatQ.delete(0);
          if (imemAddress == dirRepeatAddr) dirRepeatSeen++;
        end
      end else if (imemAddress != prevAddr + 32'd4) begin
        $display("FAIL imemAddress: expected %h, got %h", prevAddr + 32'd4, imemAddress);
        errFetch++;
      end
      prevAddr = imemAddress;
      if (dmemWrEn) checkStore();
    end
  end

  // Watchdog scaled to the program length
  initial begin
    wait (programReady);
    repeat ((progLen + 40) * 2) @(posedge Clock);
    $display("Timeout: %0d of %0d stores seen", storesSeen, expAddr.size());
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    seed       = 26122;
    reset      = 1'b1;
    imemData   = nopInstruction;
    dmemRdData = '0;
    lastLoadRd = 5'd0;
    for (int i = 0; i < 256; i++) prog[i] = nopInstruction; // NOP padding
    for (int i = 0; i < 64; i++) begin
      dmem[i]  = fillWord(i);
      mdmem[i] = fillWord(i);
    end
    for (int i = 0; i < 32; i++) mreg[i] = '0;
    buildProgram();
    repeat (10) @(posedge Clock);
    reset <= 1'b0;
    // Drain until every store is seen and fetch is well past the program
    while (!(storesSeen >= expAddr.size() &&
             imemAddress >= resetPc + 32'(4 * (progLen + 8)))) @(posedge Clock);
    if (repeatQ.size() != 0) begin
      $display("Missing %0d load-use fetch repeats", repeatQ.size());
      errStall++;
    end
    if (dirRepeatSeen != 1) begin
      $display("Directed load-use pair gave %0d repeats instead of one", dirRepeatSeen);
      errStall++;
    end
    $display("Test fetch order finished, %0d errors", errFetch);
    $display("Test load-use stall finished, %0d errors", errStall);
    $display("Test store stream finished, %0d of %0d stores, %0d errors",
             storesSeen, expAddr.size(), errStore);
    $display("Test final register stores finished, %0d errors", errFinal);
    $display("Test x0 writes finished, %0d errors", errZero);
    totalErr = errReset + errFetch + errStall + errStore + errFinal + errZero;
    $display("Checks: %0d, errors: %0d", checks, totalErr);
    if (totalErr == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_rvCore

`default_nettype wire
